// ==== verilog/csi2_params.svh ====
`ifndef CSI2_PARAMS_SVH
`define CSI2_PARAMS_SVH

// lane count, fixed by the byte-pair format
`define CSI2_LANES      2

// csi-2 data type codes, low six bits of the data id
`define CSI2_DT_FS      6'h00
`define CSI2_DT_FE      6'h01
`define CSI2_DT_RAW10   6'h2B

// apb register byte offsets
`define CSI2_REG_ID     8'h00
`define CSI2_REG_CTRL   8'h04
`define CSI2_REG_FRAMES 8'h08
`define CSI2_REG_LINES  8'h0C
`define CSI2_REG_PAIRS  8'h10
`define CSI2_REG_STATUS 8'h14

`define CSI2_ID_WORD    32'h01234567
`define CSI2_CNT_W      16

`endif

// ==== verilog/csi2_pkg.sv ====
`include "csi2_params.svh"

package csi2_pkg;

	// outputs of one d-phy data lane
	typedef struct packed {
		logic [7:0] rxdatahs;
		logic       rxvalidhs;
		logic       rxactivehs;
		logic       rxsynchs;
	} dphy_lane_t;

	// data[0] from lane 0, data[1] from lane 1
	typedef struct packed {
		logic [`CSI2_LANES-1:0][7:0] data;
		logic                        first;
	} byte_pair_t;

	typedef struct packed {
		logic [`CSI2_LANES-1:0][7:0] data;
		logic                        valid;
		logic                        last;
	} payload_t;

	// pix[0] is the earlier pixel on the line
	typedef struct packed {
		logic [1:0][9:0] pix;
		logic            valid;
		logic            frame_start;
		logic            line_end;
	} pixel_pair_t;

	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [7:0]  paddr;
		logic [31:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [31:0] prdata;
		logic        pready;
		logic        pslverr;
	} apb_rsp_t;

	typedef enum logic [1:0] {IDLE, HDR1, PAYLOAD, SKIP_CRC} parse_state_e;

	typedef enum logic [5:0] {
		DT_FS    = `CSI2_DT_FS,
		DT_FE    = `CSI2_DT_FE,
		DT_RAW10 = `CSI2_DT_RAW10
	} data_type_e;

endpackage

// ==== verilog/csi2_lane_merge.sv ====
`timescale 1ns/1ns

module csi2_lane_merge (
	input  logic                 rxbyteclkhs,
	input  logic                 rst_i,
	input  csi2_pkg::dphy_lane_t lane0_i,
	input  csi2_pkg::dphy_lane_t lane1_i,
	output csi2_pkg::byte_pair_t pair_o,
	output logic                 pair_valid_o,
	output logic                 align_err_o
);

	logic            both_valid;
	logic            both_active;
	logic            sync_pend;
	logic            first_q;
	logic [1:0][7:0] data_q;

	assign both_valid  = lane0_i.rxvalidhs & lane1_i.rxvalidhs;
	assign both_active = lane0_i.rxactivehs & lane1_i.rxactivehs;

	always_ff @(posedge rxbyteclkhs) begin
		if (rst_i) begin
			pair_valid_o <= 1'b0;
			align_err_o  <= 1'b0;
			sync_pend    <= 1'b0;
			first_q      <= 1'b0;
		end else begin
			pair_valid_o <= both_valid;
			// lanes out of step while both are in hs mode
			align_err_o  <= both_active & (lane0_i.rxvalidhs ^ lane1_i.rxvalidhs);
			if (both_valid) begin
				// sync seen now or earlier marks this pair as packet start
				first_q   <= sync_pend | lane0_i.rxsynchs;
				sync_pend <= 1'b0;
			end else if (lane0_i.rxsynchs) begin
				sync_pend <= 1'b1;
			end
		end
	end

	always_ff @(posedge rxbyteclkhs) begin
		if (both_valid) begin
			data_q <= {lane1_i.rxdatahs, lane0_i.rxdatahs};
		end
	end

	assign pair_o = '{data: data_q, first: first_q};

	// a pair is only issued out of an active hs burst on lane 0
	a_valid_in_burst: assert property (@(posedge rxbyteclkhs) disable iff (rst_i)
		pair_valid_o |-> $past(lane0_i.rxactivehs));

endmodule

// ==== verilog/csi2_packet_parser.sv ====
`timescale 1ns/1ns
`include "csi2_params.svh"

module csi2_packet_parser (
	input  logic                 rxbyteclkhs,
	input  logic                 rst_i,
	input  logic                 enable_i,
	input  csi2_pkg::byte_pair_t pair_i,
	input  logic                 pair_valid_i,
	output csi2_pkg::payload_t   payload_o,
	output logic                 frame_start_o,
	output logic                 frame_end_o,
	output logic                 pkt_err_o
);

	import csi2_pkg::*;

	parse_state_e           state;
	data_type_e             dt;
	logic [7:0]             wc_lo;
	logic [`CSI2_CNT_W-1:0] word_cnt;
	logic [`CSI2_CNT_W-1:0] pairs_left;
	logic                   pl_valid;
	logic                   pl_last;
	logic [1:0][7:0]        pl_data;

	// high byte of the word count sits on lane 0 of the second pair
	assign word_cnt = {pair_i.data[0], wc_lo};

	// ------------------------------------------------------------------------
	// header fsm
	// ------------------------------------------------------------------------
	always_ff @(posedge rxbyteclkhs) begin
		if (rst_i) begin
			state         <= IDLE;
			pairs_left    <= '0;
			pl_valid      <= 1'b0;
			pl_last       <= 1'b0;
			frame_start_o <= 1'b0;
			frame_end_o   <= 1'b0;
			pkt_err_o     <= 1'b0;
		end else begin
			pl_valid      <= 1'b0;
			frame_start_o <= 1'b0;
			frame_end_o   <= 1'b0;
			pkt_err_o     <= 1'b0;
			if (!enable_i) begin
				state <= IDLE;
			end else if (pair_valid_i && pair_i.first) begin
				// new header always restarts, a cut payload counts as error
				pkt_err_o <= (state == PAYLOAD);
				state     <= HDR1;
			end else if (pair_valid_i) begin
				case (state)
					HDR1: begin
						state <= IDLE;
						case (dt)
							DT_FS: frame_start_o <= 1'b1;
							DT_FE: frame_end_o <= 1'b1;
							DT_RAW10: begin
								// raw10 lines come in whole 10-byte groups
								if (word_cnt != '0 && word_cnt % 10 == 0) begin
									pairs_left <= word_cnt >> 1;
									state      <= PAYLOAD;
								end else begin
									pkt_err_o <= 1'b1;
								end
							end
							default: pkt_err_o <= 1'b1;
						endcase
					end
					PAYLOAD: begin
						pl_valid   <= 1'b1;
						pl_last    <= (pairs_left == 1);
						pairs_left <= pairs_left - 1'b1;
						if (pairs_left == 1) begin
							state <= SKIP_CRC;
						end
					end
					// crc pair dropped, wait for next sync
					default: state <= IDLE;
				endcase
			end
		end
	end

	// header fields and payload bytes
	always_ff @(posedge rxbyteclkhs) begin
		if (pair_valid_i && pair_i.first) begin
			dt    <= data_type_e'(pair_i.data[0][5:0]);
			wc_lo <= pair_i.data[1];
		end
		pl_data <= pair_i.data;
	end

	assign payload_o = '{data: pl_data, valid: pl_valid, last: pl_last};

	// payload only out of PAYLOAD, pair counter never run dry there
	a_payload_state: assert property (@(posedge rxbyteclkhs) disable iff (rst_i)
		pl_valid |-> $past(state == PAYLOAD && pairs_left != '0));

endmodule

// ==== verilog/csi2_raw10_unpack.sv ====
`timescale 1ns/1ns

module csi2_raw10_unpack (
	input  logic                  rxbyteclkhs,
	input  logic                  rst_i,
	input  csi2_pkg::payload_t    payload_i,
	input  logic                  frame_start_i,
	output csi2_pkg::pixel_pair_t pix_o
);

	logic [3:0][15:0] fill_q;
	logic [2:0]       fill_cnt;
	logic             grp_done;
	logic [9:0][7:0]  drain_q;
	logic             drain_act;
	logic [1:0]       drain_idx;
	logic             drain_last;
	logic             drain_fs;
	logic             fs_pend;
	logic [4:0][7:0]  half;
	logic [1:0]       n0;

	// byte n of a 5-byte group, low bits packed in byte 4
	function automatic logic [9:0] raw10_pix(input logic [4:0][7:0] grp, input logic [1:0] n);
		raw10_pix = {grp[n], grp[4][2*n +: 2]};
	endfunction

	assign grp_done = payload_i.valid & (fill_cnt == 3'd4);

	always_ff @(posedge rxbyteclkhs) begin
		if (rst_i) begin
			fill_cnt   <= '0;
			fs_pend    <= 1'b0;
			drain_act  <= 1'b0;
			drain_idx  <= '0;
			drain_last <= 1'b0;
			drain_fs   <= 1'b0;
		end else begin
			if (payload_i.valid) begin
				fill_cnt <= (grp_done || payload_i.last) ? 3'd0 : fill_cnt + 3'd1;
			end
			if (frame_start_i) begin
				fs_pend <= 1'b1;
			end else if (grp_done) begin
				fs_pend <= 1'b0;
			end
			// full group moves to the drain side, fill side starts over
			if (grp_done) begin
				drain_act  <= 1'b1;
				drain_idx  <= '0;
				drain_last <= payload_i.last;
				drain_fs   <= fs_pend;
			end else if (drain_act) begin
				drain_act <= (drain_idx != 2'd3);
				drain_idx <= drain_idx + 2'd1;
			end
		end
	end

	always_ff @(posedge rxbyteclkhs) begin
		if (payload_i.valid && !grp_done) begin
			fill_q[fill_cnt[1:0]] <= payload_i.data;
		end
		if (grp_done) begin
			drain_q <= {payload_i.data, fill_q};
		end
	end

	// pairs 0,1 from bytes 0..4, pairs 2,3 from bytes 5..9
	assign half = drain_idx[1] ? drain_q[9:5] : drain_q[4:0];
	assign n0   = {drain_idx[0], 1'b0};

	assign pix_o = '{
		pix:         {raw10_pix(half, n0 | 2'd1), raw10_pix(half, n0)},
		valid:       drain_act,
		frame_start: drain_act & drain_fs & (drain_idx == 2'd0),
		line_end:    drain_act & drain_last & (drain_idx == 2'd3)
	};

	// next group may only land on the final drain cycle
	a_no_overflow: assert property (@(posedge rxbyteclkhs) disable iff (rst_i)
		grp_done && drain_act |-> drain_idx == 2'd3);

endmodule

// ==== verilog/csi2_apb_regs.sv ====
`timescale 1ns/1ns
`include "csi2_params.svh"

module csi2_apb_regs (
	input  logic               rxbyteclkhs,
	input  logic               rst_i,
	input  csi2_pkg::apb_req_t apb_i,
	output csi2_pkg::apb_rsp_t apb_o,
	output logic               enable_o,
	input  logic               frame_start_i,
	input  logic               frame_end_i,
	input  logic               line_end_i,
	input  logic               pair_valid_i,
	input  logic               align_err_i,
	input  logic               pkt_err_i
);

	logic                   access;
	logic                   wr;
	logic                   mapped;
	logic [31:0]            rdata;
	logic                   err_sticky;
	logic [`CSI2_CNT_W-1:0] frame_cnt;
	logic [`CSI2_CNT_W-1:0] line_run;
	logic [`CSI2_CNT_W-1:0] lines_q;
	logic [`CSI2_CNT_W-1:0] pair_run;
	logic [`CSI2_CNT_W-1:0] pairs_q;

	// zero wait states, answer in the access cycle
	assign access = apb_i.psel & apb_i.penable;
	assign wr     = access & apb_i.pwrite;

	always_comb begin
		mapped = 1'b1;
		rdata  = '0;
		case (apb_i.paddr)
			`CSI2_REG_ID:     rdata = `CSI2_ID_WORD;
			`CSI2_REG_CTRL:   rdata = {31'h0, enable_o};
			`CSI2_REG_FRAMES: rdata = 32'(frame_cnt);
			`CSI2_REG_LINES:  rdata = 32'(lines_q);
			`CSI2_REG_PAIRS:  rdata = 32'(pairs_q);
			`CSI2_REG_STATUS: rdata = {31'h0, err_sticky};
			default:          mapped = 1'b0;
		endcase
	end

	assign apb_o = '{prdata: rdata, pready: access, pslverr: access & ~mapped};

	always_ff @(posedge rxbyteclkhs) begin
		if (rst_i) begin
			enable_o   <= 1'b0;
			err_sticky <= 1'b0;
			frame_cnt  <= '0;
			line_run   <= '0;
			lines_q    <= '0;
			pair_run   <= '0;
			pairs_q    <= '0;
		end else begin
			if (wr && apb_i.paddr == `CSI2_REG_CTRL) begin
				enable_o <= apb_i.pwdata[0];
			end
			// new errors win over a write-one clear
			if (align_err_i || pkt_err_i) begin
				err_sticky <= 1'b1;
			end else if (wr && apb_i.paddr == `CSI2_REG_STATUS && apb_i.pwdata[0]) begin
				err_sticky <= 1'b0;
			end
			if (frame_end_i) begin
				frame_cnt <= frame_cnt + 1'b1;
			end
			// line_end rides on the last valid pair of the line
			if (line_end_i) begin
				pairs_q  <= pair_run + 1'b1;
				pair_run <= '0;
			end else if (frame_start_i) begin
				pair_run <= '0;
			end else if (pair_valid_i) begin
				pair_run <= pair_run + 1'b1;
			end
			if (frame_end_i) begin
				lines_q  <= line_run;
				line_run <= '0;
			end else if (frame_start_i) begin
				line_run <= '0;
			end else if (line_end_i) begin
				line_run <= line_run + 1'b1;
			end
		end
	end

	// every access phase follows exactly one setup phase
	a_apb_phase: assert property (@(posedge rxbyteclkhs) disable iff (rst_i)
		apb_i.penable |-> apb_i.psel && $past(apb_i.psel && !apb_i.penable));

endmodule

// ==== verilog/csi2_rx_top.sv ====
`timescale 1ns/1ns

module csi2_rx_top (
	input  logic                  rxbyteclkhs,
	input  logic                  rst_i,
	input  csi2_pkg::dphy_lane_t  lane0_i,
	input  csi2_pkg::dphy_lane_t  lane1_i,
	input  csi2_pkg::apb_req_t    apb_i,
	output csi2_pkg::apb_rsp_t    apb_o,
	output csi2_pkg::pixel_pair_t pix_o
);

	import csi2_pkg::*;

	byte_pair_t pair;
	payload_t   payload;
	logic       pair_valid;
	logic       align_err;
	logic       enable;
	logic       frame_start;
	logic       frame_end;
	logic       pkt_err;

	// --------------------------------------------------------------------------
	// video path, lanes to pixel pairs
	// --------------------------------------------------------------------------
	csi2_lane_merge u_merge (.rxbyteclkhs, .rst_i, .lane0_i, .lane1_i,
		.pair_o(pair), .pair_valid_o(pair_valid), .align_err_o(align_err));

	csi2_packet_parser u_parser (.rxbyteclkhs, .rst_i, .enable_i(enable),
		.pair_i(pair), .pair_valid_i(pair_valid), .payload_o(payload),
		.frame_start_o(frame_start), .frame_end_o(frame_end), .pkt_err_o(pkt_err));

	csi2_raw10_unpack u_unpack (.rxbyteclkhs, .rst_i, .payload_i(payload),
		.frame_start_i(frame_start), .pix_o);

	// host registers, counters fed from the pixel stream
	csi2_apb_regs u_regs (.rxbyteclkhs, .rst_i, .apb_i, .apb_o, .enable_o(enable),
		.frame_start_i(frame_start), .frame_end_i(frame_end),
		.line_end_i(pix_o.line_end), .pair_valid_i(pix_o.valid),
		.align_err_i(align_err), .pkt_err_i(pkt_err));

endmodule

// ==== sim/csi2_rx_checker.sv ====
`timescale 1ns/1ns
`include "csi2_params.svh"

module csi2_rx_checker (
	input  logic                  rxbyteclkhs,
	input  logic                  rst_i,
	input  logic                  enabled_i,
	input  logic                  drain_chk_i,
	input  csi2_pkg::dphy_lane_t  lane0_i,
	input  csi2_pkg::dphy_lane_t  lane1_i,
	input  csi2_pkg::pixel_pair_t pix_i,
	input  csi2_pkg::apb_req_t    apb_req_i,
	input  csi2_pkg::apb_rsp_t    apb_rsp_i,
	input  logic                  exp_chk_i,
	input  logic [31:0]           exp_rdata_i,
	input  logic                  exp_slverr_i,
	output int                    pending_o,
	output int                    pix_errs_o,
	output int                    miss_errs_o,
	output int                    reg_errs_o
);

	import csi2_pkg::*;

	pixel_pair_t expq[$];
	pixel_pair_t exp_p;
	int          hdr_pos;
	int          nbytes;
	logic [5:0]  dt;
	logic [7:0]  wc_lo;
	logic [15:0] wc;
	logic [15:0] pairs_left;
	logic        fs_pend;
	logic [7:0]  grp_b [10];

	// ------------------------------------------------------------------------
	// reference model of the raw10 packing
	// ------------------------------------------------------------------------

	// top eight bits from byte n, low two bits from byte 4 at position 2n
	function automatic logic [9:0] pixel_of(input logic [7:0] msb, input logic [7:0] lsbs,
		input int n);
		logic [7:0] sh;
		sh = lsbs >> (2 * n);
		return {msb, sh[1:0]};
	endfunction

	// ten bytes give two halves of four pixels, two pixels per pair
	task automatic push_group(input logic last_grp);
		pixel_pair_t p;
		int h;
		int m;
		for (int k = 0; k < 4; k++) begin
			h = (k / 2) * 5;
			m = (k % 2) * 2;
			p.pix[0]      = pixel_of(grp_b[h + m], grp_b[h + 4], m);
			p.pix[1]      = pixel_of(grp_b[h + m + 1], grp_b[h + 4], m + 1);
			p.valid       = 1'b1;
			p.frame_start = fs_pend && (k == 0);
			p.line_end    = last_grp && (k == 3);
			expq.push_back(p);
		end
		fs_pend = 1'b0;
	endtask

	// one byte pair off the lanes, header first
	task automatic take_pair(input logic [7:0] b0, input logic [7:0] b1);
		case (hdr_pos)
			0: begin
				dt      = b0[5:0];
				wc_lo   = b1;
				hdr_pos = 1;
			end
			1: begin
				wc      = {b0, wc_lo};
				hdr_pos = -1;
				if (enabled_i && dt == `CSI2_DT_FS) begin
					fs_pend = 1'b1;
				end
				// only whole 10-byte groups make a line
				if (enabled_i && dt == `CSI2_DT_RAW10 && wc != 16'd0 && wc % 16'd10 == 16'd0) begin
					pairs_left = wc >> 1;
					nbytes     = 0;
					hdr_pos    = 2;
				end
			end
			2: begin
				grp_b[nbytes]     = b0;
				grp_b[nbytes + 1] = b1;
				nbytes            = nbytes + 2;
				pairs_left        = pairs_left - 16'd1;
				if (nbytes == 10) begin
					push_group(pairs_left == 16'd0);
					nbytes = 0;
				end
				// crc pair after this is not part of the line
				if (pairs_left == 16'd0) begin
					hdr_pos = -1;
				end
			end
			default: begin
			end
		endcase
	endtask

	// ------------------------------------------------------------------------
	// sampled mid-cycle, away from both driving edges
	// ------------------------------------------------------------------------
	always @(negedge rxbyteclkhs) begin
		if (rst_i) begin
			hdr_pos     = -1;
			nbytes      = 0;
			fs_pend     = 1'b0;
			expq.delete();
			pix_errs_o  = 0;
			miss_errs_o = 0;
			reg_errs_o  = 0;
		end else begin
			// lane side, sync comes in its own cycle
			if (lane0_i.rxsynchs) begin
				hdr_pos = 0;
			end else if (lane0_i.rxvalidhs && lane1_i.rxvalidhs) begin
				take_pair(lane0_i.rxdatahs, lane1_i.rxdatahs);
			end
			// pixel side, in order
			if (pix_i.valid) begin
				if (expq.size() == 0) begin
					pix_errs_o++;
					$display("ERROR %0t: pixel pair %h came out with none expected",
						$time, pix_i.pix);
				end else begin
					exp_p = expq.pop_front();
					if (pix_i != exp_p) begin
						pix_errs_o++;
						$display("ERROR %0t: pixel pair %h fs %b le %b, expected %h fs %b le %b",
							$time, pix_i.pix, pix_i.frame_start, pix_i.line_end,
							exp_p.pix, exp_p.frame_start, exp_p.line_end);
					end
				end
			end
			if (drain_chk_i && expq.size() != 0) begin
				miss_errs_o++;
				$display("%0d expected pixel pairs never came out of the DUT", expq.size());
				expq.delete();
			end
			// register reads in the access cycle
			if (exp_chk_i && apb_req_i.psel && apb_req_i.penable) begin
				if (!apb_rsp_i.pready || apb_rsp_i.pslverr != exp_slverr_i ||
					(!exp_slverr_i && apb_rsp_i.prdata != exp_rdata_i)) begin
					reg_errs_o++;
					$display("ERROR %0t: read at %h gave %h err %b, expected %h err %b",
						$time, apb_req_i.paddr, apb_rsp_i.prdata, apb_rsp_i.pslverr,
						exp_rdata_i, exp_slverr_i);
				end
			end
		end
		pending_o = expq.size();
	end

endmodule

// ==== sim/csi2_rx_tb.sv ====
`timescale 1ns/1ns
`include "csi2_params.svh"

module csi2_rx_tb;

	import csi2_pkg::*;

	localparam int ROWS       = 12;
	localparam int GAP        = 4;
	localparam int DRAIN_WAIT = 32;

	logic        rxbyteclkhs = 1'b0;
	logic        rst_i;
	dphy_lane_t  lane0;
	dphy_lane_t  lane1;
	apb_req_t    apb_req;
	apb_rsp_t    apb_rsp;
	pixel_pair_t pix;
	logic        rx_en;
	logic        drain_chk;
	logic        exp_chk;
	logic [31:0] exp_rdata;
	logic        exp_slverr;
	int          pending;
	int          pix_errs;
	int          miss_errs;
	int          reg_errs;
	int          cycles = 0;
	int          limit = 0;

	// ------------------------------------------------------------------------
	// packet table: data type, word count, enable, then registers afterwards
	// ------------------------------------------------------------------------
	// frame of three lines, then two bad packets, then a frame with rx off
	logic [5:0] tab_dt [ROWS] = '{6'h00, 6'h2B, 6'h2B, 6'h2B, 6'h01, 6'h12,
		6'h2B, 6'h00, 6'h2B, 6'h2B, 6'h2B, 6'h01};
	int tab_wc [ROWS]     = '{1, 40, 20, 30, 1, 40, 36, 2, 40, 40, 40, 2};
	logic tab_en [ROWS]   = '{1, 1, 1, 1, 1, 1, 1, 0, 0, 0, 0, 0};
	int tab_frames [ROWS] = '{0, 0, 0, 0, 1, 1, 1, 1, 1, 1, 1, 1};
	int tab_lines [ROWS]  = '{0, 0, 0, 0, 3, 3, 3, 3, 3, 3, 3, 3};
	int tab_pairs [ROWS]  = '{0, 16, 8, 12, 12, 12, 12, 12, 12, 12, 12, 12};
	logic tab_err [ROWS]  = '{0, 0, 0, 0, 0, 1, 1, 0, 0, 0, 0, 0};

	always #20 rxbyteclkhs = ~rxbyteclkhs;

	csi2_rx_top csi2_rx_top_i (.rxbyteclkhs, .rst_i, .lane0_i(lane0), .lane1_i(lane1),
		.apb_i(apb_req), .apb_o(apb_rsp), .pix_o(pix));

	csi2_rx_checker u_checker (.rxbyteclkhs, .rst_i, .enabled_i(rx_en),
		.drain_chk_i(drain_chk), .lane0_i(lane0), .lane1_i(lane1), .pix_i(pix),
		.apb_req_i(apb_req), .apb_rsp_i(apb_rsp), .exp_chk_i(exp_chk),
		.exp_rdata_i(exp_rdata), .exp_slverr_i(exp_slverr), .pending_o(pending),
		.pix_errs_o(pix_errs), .miss_errs_o(miss_errs), .reg_errs_o(reg_errs));

	// sync cycle, header, payload and crc for long packets, idle gap
	function automatic int pkt_cycles(input logic [5:0] dt, input int wc);
		return 1 + ((dt > 6'h0F) ? (wc + 6) / 2 : 2) + GAP;
	endfunction

	task automatic drive_lanes(input logic act, input logic vld, input logic sync,
		input logic [7:0] d0, input logic [7:0] d1);
		@(posedge rxbyteclkhs);
		#2;
		lane0 = '{rxdatahs: d0, rxvalidhs: vld, rxactivehs: act, rxsynchs: sync};
		lane1 = '{rxdatahs: d1, rxvalidhs: vld, rxactivehs: act, rxsynchs: sync};
	endtask

	task automatic send_packet(input logic [5:0] dt, input int wc);
		logic [7:0] pkt_b [$];
		pkt_b.push_back({2'b00, dt});
		pkt_b.push_back(8'(wc));
		pkt_b.push_back(8'(wc >> 8));
		pkt_b.push_back(8'($urandom()));
		if (dt > 6'h0F) begin
			// payload then two crc bytes
			for (int i = 0; i < wc + 2; i++) begin
				pkt_b.push_back(8'($urandom()));
			end
		end
		drive_lanes(1'b1, 1'b0, 1'b1, 8'h00, 8'h00);
		for (int i = 0; i < pkt_b.size(); i += 2) begin
			drive_lanes(1'b1, 1'b1, 1'b0, pkt_b[i], pkt_b[i + 1]);
		end
		repeat (GAP) drive_lanes(1'b0, 1'b0, 1'b0, 8'h00, 8'h00);
	endtask

	// setup cycle, access cycle, then idle
	task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
		input logic [31:0] rdata, input logic slverr);
		@(posedge rxbyteclkhs);
		#2;
		apb_req    = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
		exp_chk    = !wr;
		exp_rdata  = rdata;
		exp_slverr = slverr;
		@(posedge rxbyteclkhs);
		#2;
		apb_req.penable = 1'b1;
		@(posedge rxbyteclkhs);
		#2;
		apb_req = '0;
		exp_chk = 1'b0;
	endtask

	// pixels of the last group drain a few cycles after the lanes
	task automatic wait_drain();
		int n;
		n = 0;
		while (pending != 0 && n < DRAIN_WAIT) begin
			@(posedge rxbyteclkhs);
			n++;
		end
		@(posedge rxbyteclkhs);
		#2;
		drain_chk = 1'b1;
		@(posedge rxbyteclkhs);
		#2;
		drain_chk = 1'b0;
	endtask

	initial begin
		lane0      = '0;
		lane1      = '0;
		apb_req    = '0;
		rst_i      = 1'b1;
		rx_en      = 1'b0;
		drain_chk  = 1'b0;
		exp_chk    = 1'b0;
		exp_rdata  = '0;
		exp_slverr = 1'b0;
		void'($urandom(32'h4dc6));
		for (int r = 0; r < ROWS; r++) begin
			limit += 2 * pkt_cycles(tab_dt[r], tab_wc[r]);
		end
		limit += 200;
		repeat (16) @(posedge rxbyteclkhs);
		#2;
		rst_i = 1'b0;

		apb_access(1'b0, `CSI2_REG_ID, '0, `CSI2_ID_WORD, 1'b0);
		apb_access(1'b0, 8'h18, '0, '0, 1'b1);

		for (int r = 0; r < ROWS; r++) begin
			if (tab_en[r] != rx_en) begin
				apb_access(1'b1, `CSI2_REG_CTRL, {31'h0, tab_en[r]}, '0, 1'b0);
				rx_en = tab_en[r];
			end
			send_packet(tab_dt[r], tab_wc[r]);
			wait_drain();
			apb_access(1'b0, `CSI2_REG_FRAMES, '0, 32'(tab_frames[r]), 1'b0);
			apb_access(1'b0, `CSI2_REG_LINES, '0, 32'(tab_lines[r]), 1'b0);
			apb_access(1'b0, `CSI2_REG_PAIRS, '0, 32'(tab_pairs[r]), 1'b0);
			apb_access(1'b0, `CSI2_REG_STATUS, '0, {31'h0, tab_err[r]}, 1'b0);
			if (tab_err[r]) begin
				// write one to clear the sticky flag
				apb_access(1'b1, `CSI2_REG_STATUS, 32'h1, '0, 1'b0);
				apb_access(1'b0, `CSI2_REG_STATUS, '0, '0, 1'b0);
			end
		end

		$display("errors: pixel %0d, missing %0d, register %0d", pix_errs, miss_errs, reg_errs);
		if (pix_errs == 0 && miss_errs == 0 && reg_errs == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

	always @(posedge rxbyteclkhs) begin
		cycles++;
		if (cycles >= limit) begin
			$display("timeout: the packet table did not finish within %0d cycles", limit);
			$display("=== FAIL ===");
			$finish;
		end
	end

endmodule

// ==== verilog.f ====
+incdir+verilog
verilog/csi2_pkg.sv
verilog/csi2_lane_merge.sv
verilog/csi2_packet_parser.sv
verilog/csi2_raw10_unpack.sv
verilog/csi2_apb_regs.sv
verilog/csi2_rx_top.sv
sim/csi2_rx_checker.sv
sim/csi2_rx_tb.sv

// ==== run.sh ====
#!/bin/sh
# build with Verilator and run, fail if the log reports a failure
rm -f sim.log
verilator --binary --timing --assert -f verilog.f --top-module csi2_rx_tb \
	&& ./obj_dir/Vcsi2_rx_tb > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "=== FAIL ===" sim.log && exit 1 || exit 0
